// ==== Bender.yml ====
package:
  name: engine_merge_data

sources:
  # RTL in compile order
  - files:
      - hdl/merge_data_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/merge_control.sv
      - hdl/merge_lane_combiner.sv
      - hdl/engine_merge_data.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/engine_merge_data_checker.sv
      - testbench/tb_engine_merge_data.sv

// ==== hdl/engine_merge_data.sv ====
`timescale 1ns/10ps
`default_nettype none

module engine_merge_data #(
    parameter int MERGE_LANES = 4,
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic                               ap_clk,
    input  logic                               areset_csr_engine,
    input  merge_data_pkg::kernel_descriptor_t descriptor_in,
    input  merge_data_pkg::merge_config_t      response_memory_in,
    input  merge_data_pkg::merge_packet_t      response_engine_in [MERGE_LANES-1:0],
    output logic [MERGE_LANES-1:0]             response_engine_ready,
    input  logic                               request_engine_rd_en,
    output merge_data_pkg::merge_packet_t      request_engine_out,
    output logic                               done_out
);

    // Input registers
    merge_data_pkg::kernel_descriptor_t descriptor_reg;
    merge_data_pkg::merge_config_t      config_reg;
    merge_data_pkg::merge_packet_t      lane_in_reg [MERGE_LANES-1:0];
    logic                               rd_en_reg;

    // Lane FIFO side
    merge_data_pkg::data_word_t    lane_dout [MERGE_LANES-1:0];
    merge_data_pkg::merge_packet_t lane_data [MERGE_LANES-1:0];
    logic [MERGE_LANES-1:0]        lane_valid;
    logic [MERGE_LANES-1:0]        lane_empty;
    logic [MERGE_LANES-1:0]        lane_prog_full;
    logic [MERGE_LANES-1:0]        lane_pop;

    // Control and combiner
    merge_data_pkg::merge_op_e     merge_op;
    merge_data_pkg::lane_mask_t    lane_mask;
    merge_data_pkg::merge_packet_t result;
    logic                          ctrl_idle;

    // Output FIFO side
    merge_data_pkg::data_word_t out_dout;
    logic                       out_valid;
    logic                       out_empty;
    logic                       out_prog_full;
    logic                       out_rd_en;
    logic                       all_empty;

    // ----------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        descriptor_reg.rounds <= descriptor_in.rounds;
        config_reg.op         <= response_memory_in.op;
        config_reg.lane_mask  <= response_memory_in.lane_mask;
        for (int i = 0; i < MERGE_LANES; i++) begin
            lane_in_reg[i].data <= response_engine_in[i].data;
        end
        if (areset_csr_engine) begin
            descriptor_reg.valid <= 1'b0;
            config_reg.valid     <= 1'b0;
            rd_en_reg            <= 1'b0;
            for (int i = 0; i < MERGE_LANES; i++) begin
                lane_in_reg[i].valid <= 1'b0;
            end
        end else begin
            descriptor_reg.valid <= descriptor_in.valid;
            config_reg.valid     <= response_memory_in.valid;
            rd_en_reg            <= request_engine_rd_en;
            for (int i = 0; i < MERGE_LANES; i++) begin
                lane_in_reg[i].valid <= response_engine_in[i].valid;
            end
        end
    end

    // ----------------------------------------------------------
    // Lane FIFOs
    // ----------------------------------------------------------
    for (genvar i = 0; i < MERGE_LANES; i++) begin : gen_lane
        sync_fifo #(
            .WIDTH      (merge_data_pkg::DATA_W),
            .DEPTH      (FIFO_DEPTH),
            .PROG_THRESH(PROG_THRESH)
        ) i_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_csr_engine(areset_csr_engine),
            .din              (lane_in_reg[i].data),
            .wr_en            (lane_in_reg[i].valid),
            .rd_en            (lane_pop[i]),
            .dout             (lane_dout[i]),
            .valid            (lane_valid[i]),
            .empty            (lane_empty[i]),
            .full             (),
            .prog_full        (lane_prog_full[i])
        );
    end

    always_comb begin
        for (int i = 0; i < MERGE_LANES; i++) begin
            lane_data[i].valid = lane_valid[i];
            lane_data[i].data  = lane_dout[i];
        end
    end

    // ----------------------------------------------------------
    // Round control and reduction
    // ----------------------------------------------------------
    merge_control #(
        .MERGE_LANES(MERGE_LANES)
    ) i_control (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .config_in        (config_reg),
        .descriptor_in    (descriptor_reg),
        .lane_avail       (~lane_empty),
        .out_almost_full  (out_prog_full),
        .lane_pop         (lane_pop),
        .merge_op         (merge_op),
        .lane_mask        (lane_mask),
        .idle             (ctrl_idle)
    );

    merge_lane_combiner #(
        .MERGE_LANES(MERGE_LANES)
    ) i_combiner (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .lane_data        (lane_data),
        .lane_mask        (lane_mask),
        .merge_op         (merge_op),
        .result           (result)
    );

    // ----------------------------------------------------------
    // Output FIFO
    // ----------------------------------------------------------
    assign out_rd_en = rd_en_reg & ~out_empty;

    sync_fifo #(
        .WIDTH      (merge_data_pkg::DATA_W),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_out_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .din              (result.data),
        .wr_en            (result.valid),
        .rd_en            (out_rd_en),
        .dout             (out_dout),
        .valid            (out_valid),
        .empty            (out_empty),
        .full             (),
        .prog_full        (out_prog_full)
    );

    // ----------------------------------------------------------
    // Output registers and done
    // ----------------------------------------------------------
    assign all_empty = (&lane_empty) & out_empty;

    always_ff @(posedge ap_clk) begin
        request_engine_out.data <= out_dout;
        if (areset_csr_engine) begin
            request_engine_out.valid <= 1'b0;
            response_engine_ready    <= '0;
            done_out                 <= 1'b1;
        end else begin
            request_engine_out.valid <= out_valid;
            response_engine_ready    <= ~lane_prog_full;
            // Hold off done until the last result has left the output register
            done_out                 <= ctrl_idle & all_empty & ~out_valid;
        end
    end

endmodule : engine_merge_data

`default_nettype wire

// ==== hdl/merge_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module merge_control #(
    parameter int MERGE_LANES = 4
) (
    input  logic                               ap_clk,
    input  logic                               areset_csr_engine,
    input  merge_data_pkg::merge_config_t      config_in,
    input  merge_data_pkg::kernel_descriptor_t descriptor_in,
    input  logic [MERGE_LANES-1:0]             lane_avail,
    input  logic                               out_almost_full,
    output logic [MERGE_LANES-1:0]             lane_pop,
    output merge_data_pkg::merge_op_e          merge_op,
    output merge_data_pkg::lane_mask_t         lane_mask,
    output logic                               idle
);

    merge_data_pkg::merge_state_e state;
    merge_data_pkg::round_count_t rounds_left;
    logic                         cfg_captured;
    logic [1:0]                   drain_cnt;
    logic [MERGE_LANES-1:0]       lane_en;
    logic                         round_go;

    assign lane_en = lane_mask[MERGE_LANES-1:0];

    // All enabled lanes hold data and the output FIFO has room
    assign round_go = (state == merge_data_pkg::RUN) &
                      (&(lane_avail | ~lane_en)) &
                      ~out_almost_full;

    assign lane_pop = round_go ? lane_en : '0;
    assign idle     = (state == merge_data_pkg::IDLE);

    // ----------------------------------------------------------
    // Config capture
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_captured <= 1'b0;
            merge_op     <= merge_data_pkg::MERGE_SUM;
            lane_mask    <= '0;
        end else if (idle && config_in.valid) begin
            cfg_captured <= 1'b1;
            merge_op     <= config_in.op;
            lane_mask    <= config_in.lane_mask;
        end
    end

    // ----------------------------------------------------------
    // Round state machine
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state       <= merge_data_pkg::IDLE;
            rounds_left <= '0;
            drain_cnt   <= '0;
        end else begin
            case (state)
                merge_data_pkg::IDLE: begin
                    // Zero rounds leaves the engine idle
                    if (descriptor_in.valid && cfg_captured && (descriptor_in.rounds != '0)) begin
                        rounds_left <= descriptor_in.rounds;
                        state       <= merge_data_pkg::RUN;
                    end
                end
                merge_data_pkg::RUN: begin
                    if (round_go) begin
                        rounds_left <= rounds_left - 1'b1;
                        if (rounds_left == merge_data_pkg::round_count_t'(1)) begin
                            drain_cnt <= '0;
                            state     <= merge_data_pkg::DRAIN;
                        end
                    end
                end
                merge_data_pkg::DRAIN: begin
                    // FIFO read stage, then combiner stage
                    if (drain_cnt == 2'd1) begin
                        state <= merge_data_pkg::IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= merge_data_pkg::IDLE;
                end
            endcase
        end
    end

endmodule : merge_control

`default_nettype wire

// ==== hdl/merge_data_pkg.sv ====
`default_nettype none

package merge_data_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int DATA_W    = 32;
    localparam int MAX_LANES = 8;

    typedef logic [DATA_W-1:0]    data_word_t;
    typedef logic [15:0]          round_count_t;
    typedef logic [MAX_LANES-1:0] lane_mask_t;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------
    typedef enum logic {
        MERGE_SUM = 1'b0,
        MERGE_MAX = 1'b1
    } merge_op_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } merge_state_e;

    // ----------------------------------------------------------
    // Packets and control words
    // ----------------------------------------------------------
    typedef struct packed {
        logic       valid;
        data_word_t data;
    } merge_packet_t;

    // Config word from the memory response port
    typedef struct packed {
        logic       valid;
        merge_op_e  op;
        lane_mask_t lane_mask;
    } merge_config_t;

    typedef struct packed {
        logic         valid;
        round_count_t rounds;
    } kernel_descriptor_t;

endpackage : merge_data_pkg

`default_nettype wire

// ==== hdl/merge_lane_combiner.sv ====
`timescale 1ns/10ps
`default_nettype none

module merge_lane_combiner #(
    parameter int MERGE_LANES = 4
) (
    input  logic                          ap_clk,
    input  logic                          areset_csr_engine,
    input  merge_data_pkg::merge_packet_t lane_data [MERGE_LANES-1:0],
    input  merge_data_pkg::lane_mask_t    lane_mask,
    input  merge_data_pkg::merge_op_e     merge_op,
    output merge_data_pkg::merge_packet_t result
);

    merge_data_pkg::data_word_t reduced;
    logic                       any_valid;

    // ----------------------------------------------------------
    // Reduction over enabled lanes
    // ----------------------------------------------------------
    // Disabled lanes act as zero, neutral for both sum and max
    always_comb begin
        reduced   = '0;
        any_valid = 1'b0;
        for (int i = 0; i < MERGE_LANES; i++) begin
            if (lane_mask[i]) begin
                any_valid = any_valid | lane_data[i].valid;
                if (merge_op == merge_data_pkg::MERGE_SUM) begin
                    // Wraps at DATA_W bits
                    reduced = reduced + lane_data[i].data;
                end else if (lane_data[i].data > reduced) begin
                    reduced = lane_data[i].data;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Result register
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        result.data <= reduced;
        if (areset_csr_engine) begin
            result.valid <= 1'b0;
        end else begin
            // Enabled lanes pop together
            result.valid <= any_valid;
        end
    end

endmodule : merge_lane_combiner

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic             ap_clk,
    input  logic             areset_csr_engine,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_write;
    logic             do_read;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        logic [AW-1:0] nxt;
        if (ptr == AW'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty     = (count == '0);
    assign full      = (count == CW'(DEPTH));
    assign prog_full = (count >= CW'(PROG_THRESH));

    // Overflow and underflow requests are dropped
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= do_read;
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

`default_nettype wire

// ==== sources.f ====
hdl/merge_data_pkg.sv
hdl/sync_fifo.sv
hdl/merge_control.sv
hdl/merge_lane_combiner.sv
hdl/engine_merge_data.sv
testbench/tb_clock_gen.sv
testbench/engine_merge_data_checker.sv
testbench/tb_engine_merge_data.sv

// ==== testbench/engine_merge_data_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module engine_merge_data_checker #(
    parameter int MERGE_LANES = 4
) (
    input logic                          ap_clk,
    input logic                          areset_csr_engine,
    input logic [MERGE_LANES-1:0]        response_engine_ready,
    input merge_data_pkg::merge_packet_t request_engine_out,
    input logic                          done_out
);

    // Failed assertion count for the final verdict
    int unsigned failures = 0;

    // No result leaves while the engine is done and empty
    a_quiet_when_done: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        done_out |-> !request_engine_out.valid ##1 !request_engine_out.valid
    ) else begin
        $error("result valid while done_out is high");
        failures++;
    end

    a_done_after_reset: assert property (
        @(posedge ap_clk) $fell(areset_csr_engine) |-> done_out
    ) else begin
        $error("done_out low in the first cycle after reset");
        failures++;
    end

    // Ready stays low through reset
    a_ready_low_in_reset: assert property (
        @(posedge ap_clk) areset_csr_engine |=> (response_engine_ready == '0)
    ) else begin
        $error("response_engine_ready high during reset");
        failures++;
    end

endmodule : engine_merge_data_checker

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5
) (
    output logic ap_clk
);

    // 10 ns period, starting low
    initial begin
        ap_clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) ap_clk = ~ap_clk;
        end
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== testbench/tb_engine_merge_data.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_engine_merge_data;

    localparam int LANES       = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 12;
    // Sum of the rounds in all tests (20 + 24 + 40 + 24)
    localparam int TOTAL_ROUNDS    = 108;
    localparam int WATCHDOG_CYCLES = TOTAL_ROUNDS * 40 + 2000;

    logic                               ap_clk;
    logic                               areset_csr_engine;
    merge_data_pkg::kernel_descriptor_t descriptor_in;
    merge_data_pkg::merge_config_t      response_memory_in;
    merge_data_pkg::merge_packet_t      response_engine_in [LANES-1:0];
    logic [LANES-1:0]                   response_engine_ready;
    logic                               request_engine_rd_en;
    merge_data_pkg::merge_packet_t      request_engine_out;
    logic                               done_out;

    integer                     seed = 32'he31b1464;
    merge_data_pkg::data_word_t lane_q [LANES][$];
    merge_data_pkg::data_word_t exp_q [$];
    merge_data_pkg::merge_op_e  cur_op;
    merge_data_pkg::lane_mask_t cur_mask;
    int                         sent_cnt [LANES];
    int                         out_count;
    int                         hold_cycles;
    int unsigned                r;
    merge_data_pkg::lane_mask_t mask;
    // Read enables of the last three cycles, newest in bit 0
    logic [2:0]                 rd_hist;

    tb_clock_gen i_clock_gen (
        .ap_clk(ap_clk)
    );

    engine_merge_data #(
        .MERGE_LANES(LANES),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_dut (
        .ap_clk               (ap_clk),
        .areset_csr_engine    (areset_csr_engine),
        .descriptor_in        (descriptor_in),
        .response_memory_in   (response_memory_in),
        .response_engine_in   (response_engine_in),
        .response_engine_ready(response_engine_ready),
        .request_engine_rd_en (request_engine_rd_en),
        .request_engine_out   (request_engine_out),
        .done_out             (done_out)
    );

    bind engine_merge_data engine_merge_data_checker #(
        .MERGE_LANES(MERGE_LANES)
    ) i_checker (
        .ap_clk               (ap_clk),
        .areset_csr_engine    (areset_csr_engine),
        .response_engine_ready(response_engine_ready),
        .request_engine_out   (request_engine_out),
        .done_out             (done_out)
    );

    // ----------------------------------------------------------
    // Error reporting and compare tasks
    // ----------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input merge_data_pkg::data_word_t actual,
                              input merge_data_pkg::data_word_t expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR @%0t: %s: got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_done(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR @%0t: %s: got %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_ready(input logic [LANES-1:0] actual, input logic [LANES-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR @%0t: %s: got %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_count(input merge_data_pkg::round_count_t actual,
                               input merge_data_pkg::round_count_t expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR @%0t: %s: got %0d, expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic bit round_complete();
        for (int i = 0; i < LANES; i++) begin
            if (cur_mask[i] && (lane_q[i].size() == 0)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // One expected result per full set of enabled-lane items
    task automatic update_model();
        merge_data_pkg::data_word_t acc;
        merge_data_pkg::data_word_t d;
        while (round_complete()) begin
            acc = '0;
            for (int i = 0; i < LANES; i++) begin
                if (cur_mask[i]) begin
                    d = lane_q[i].pop_front();
                    if (cur_op == merge_data_pkg::MERGE_SUM) begin
                        acc = acc + d;
                    end else if (d > acc) begin
                        acc = d;
                    end
                end
            end
            exp_q.push_back(acc);
        end
    endtask

    // ----------------------------------------------------------
    // One cycle step that samples outputs and drives the read enable
    // ----------------------------------------------------------
    task automatic next_cycle();
        int unsigned rnd;
        @(negedge ap_clk);
        if (request_engine_out.valid === 1'b1) begin
            // A result leaves three cycles after its read enable
            if (rd_hist[2] !== 1'b1) begin
                abort_run($sformatf("ERR @%0t: result came out without a read enable",
                                    $time));
            end
            if (exp_q.size() == 0) begin
                abort_run("A result came out that matches no input round");
            end
            check_data(request_engine_out.data, exp_q.pop_front(), "merged result");
            out_count++;
        end
        rnd = $random(seed);
        if (hold_cycles > 0) begin
            hold_cycles--;
            request_engine_rd_en = 1'b0;
        end else begin
            request_engine_rd_en = ((rnd % 100) >= 30);
        end
        rd_hist = {rd_hist[1:0], request_engine_rd_en};
    endtask

    task automatic configure(input merge_data_pkg::merge_op_e op,
                             input merge_data_pkg::lane_mask_t lanes);
        next_cycle();
        response_memory_in.valid     = 1'b1;
        response_memory_in.op        = op;
        response_memory_in.lane_mask = lanes;
        cur_op   = op;
        cur_mask = lanes;
        next_cycle();
        response_memory_in.valid = 1'b0;
    endtask

    task automatic start_run(input int rounds);
        out_count = 0;
        sent_cnt  = '{default: 0};
        next_cycle();
        descriptor_in.valid  = 1'b1;
        descriptor_in.rounds = merge_data_pkg::round_count_t'(rounds);
        next_cycle();
        descriptor_in.valid = 1'b0;
        repeat (2) next_cycle();
        check_done(done_out, (rounds == 0), "done_out after descriptor");
    endtask

    // Sends only while ready is high and never to skip_lane
    task automatic feed_lanes(input int rounds, input int skip_lane, input bit until_throttled);
        bit busy;
        bit throttled;
        busy = 1'b1;
        while (busy) begin
            next_cycle();
            check_done(done_out, 1'b0, "done_out during a run");
            busy      = 1'b0;
            throttled = 1'b1;
            for (int i = 0; i < LANES; i++) begin
                response_engine_in[i].valid = 1'b0;
                if (cur_mask[i] && (i != skip_lane) && (sent_cnt[i] < rounds)) begin
                    busy = 1'b1;
                    if (response_engine_ready[i]) begin
                        throttled = 1'b0;
                        if (($random(seed) & 3) != 0) begin
                            response_engine_in[i].valid = 1'b1;
                            response_engine_in[i].data  = $random(seed);
                            lane_q[i].push_back(response_engine_in[i].data);
                            sent_cnt[i]++;
                        end
                    end
                end
            end
            update_model();
            if (until_throttled && throttled) begin
                busy = 1'b0;
            end
        end
    endtask

    task automatic finish_run(input int rounds);
        int cycles;
        cycles = 0;
        while (done_out !== 1'b1) begin
            if (cycles > rounds * 40 + 500) begin
                abort_run("done_out never rose at the end of a run");
            end
            next_cycle();
            cycles++;
        end
        check_count(merge_data_pkg::round_count_t'(out_count),
                    merge_data_pkg::round_count_t'(rounds), "results read out");
        check_count(merge_data_pkg::round_count_t'(exp_q.size()), '0, "results still expected");
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        areset_csr_engine    = 1'b1;
        descriptor_in        = '0;
        response_memory_in   = '0;
        request_engine_rd_en = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            response_engine_in[i] = '0;
        end
        hold_cycles = 0;
        out_count   = 0;
        rd_hist     = '0;
        cur_op      = merge_data_pkg::MERGE_SUM;
        cur_mask    = '0;
        repeat (5) @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        next_cycle();
        check_done(done_out, 1'b1, "done_out after reset");

        // Sum over all lanes
        configure(merge_data_pkg::MERGE_SUM, 8'h0f);
        start_run(20);
        feed_lanes(20, -1, 1'b0);
        finish_run(20);

        // Max over a random partial mask
        r    = $random(seed);
        mask = merge_data_pkg::lane_mask_t'(r % 15 + 1);
        configure(merge_data_pkg::MERGE_MAX, mask);
        start_run(24);
        feed_lanes(24, -1, 1'b0);
        finish_run(24);

        // Output held back for 200 cycles
        configure(merge_data_pkg::MERGE_SUM, 8'h0f);
        start_run(40);
        hold_cycles = 200;
        feed_lanes(40, -1, 1'b0);
        finish_run(40);

        // Lane 0 starved until its siblings throttle
        configure(merge_data_pkg::MERGE_MAX, 8'h0f);
        start_run(24);
        feed_lanes(24, 0, 1'b1);
        repeat (4) next_cycle();
        check_ready(response_engine_ready, 4'b0001, "ready with lane 0 starved");
        for (int i = 1; i < LANES; i++) begin
            if ((lane_q[i].size() < PROG_THRESH) || (lane_q[i].size() > FIFO_DEPTH)) begin
                abort_run($sformatf("ERR @%0t: lane %0d throttled after %0d items",
                                    $time, i, lane_q[i].size()));
            end
        end
        feed_lanes(24, -1, 1'b0);
        finish_run(24);

        // Zero rounds keeps done high with no output
        start_run(0);
        repeat (4) begin
            next_cycle();
            check_done(done_out, 1'b1, "done_out after zero-round descriptor");
        end

        if (i_dut.i_checker.failures == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Checker reported %0d failed assertions", i_dut.i_checker.failures);
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        abort_run($sformatf("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule : tb_engine_merge_data

`default_nettype wire
